/* include/calc_params.svh */
// Sizes assume a 1-bit sign over a 15-bit magnitude; CALC_MULT_STEPS must equal CALC_MAG_WIDTH
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// Full operand and result width, sign included
`define CALC_WIDTH 16

// Magnitude bits below the sign
`define CALC_MAG_WIDTH 15

// One BCD keypad digit
`define CALC_DIGIT_WIDTH 4

// Decimal shift applied per entered digit
`define CALC_ENTRY_SCALE 10

// One shift-and-add step per magnitude bit
`define CALC_MULT_STEPS 15

`endif

/* logic/calc_pkg.sv */
// Opcode values must match the external input controller; key fields are one-cycle strobes
`include "calc_params.svh"

package calc_pkg;

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } opcode_t;

    typedef enum logic [3:0] {
        WAIT_OP1,
        SHIFT_OP1,
        ADD_DIGIT_OP1,
        WAIT_OP2,
        SHIFT_OP2,
        ADD_DIGIT_OP2,
        SEND_COMPUTE,
        WAIT_COMPUTE,
        SHOW_ADDSUB,
        SHOW_MULT
    } state_t;

    // Multiplier feeds either the operand times ten or A times B
    typedef enum logic {
        MSRC_ENTRY,
        MSRC_COMPUTE
    } mult_src_t;

    typedef struct packed {
        logic [`CALC_DIGIT_WIDTH-1:0] digit;
        logic                         digit_valid;
        opcode_t                      op;
        logic                         equal;
    } key_event_t;

endpackage

/* logic/sm_adder.sv */
// Result holds until the next start; magnitudes wrap modulo 2^15 and zero is always positive
`timescale 1ns/1ps
`include "calc_params.svh"

module sm_adder (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   start,
    input  logic                   sub,
    input  logic [`CALC_WIDTH-1:0] a,
    input  logic [`CALC_WIDTH-1:0] b,
    output logic [`CALC_WIDTH-1:0] result,
    output logic                   finish
);

    logic                       a_sign;
    logic                       b_sign;
    logic [`CALC_MAG_WIDTH-1:0] a_mag;
    logic [`CALC_MAG_WIDTH-1:0] b_mag;
    logic [`CALC_MAG_WIDTH-1:0] res_mag;
    logic                       res_sign;

    assign a_sign = a[`CALC_WIDTH-1];
    // Subtraction is addition of the negated b
    assign b_sign = b[`CALC_WIDTH-1] ^ sub;
    assign a_mag  = a[`CALC_MAG_WIDTH-1:0];
    assign b_mag  = b[`CALC_MAG_WIDTH-1:0];

    always_comb begin
        if (a_sign == b_sign) begin
            res_mag  = a_mag + b_mag;
            res_sign = a_sign;
        end else if (a_mag >= b_mag) begin
            res_mag  = a_mag - b_mag;
            res_sign = a_sign;
        end else begin
            res_mag  = b_mag - a_mag;
            res_sign = b_sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    // Plus sign on a zero magnitude
    always_ff @(posedge clk) begin
        if (start) begin
            result <= {res_sign & (|res_mag), res_mag};
        end
    end

endmodule

/* logic/sm_multiplier.sv */
// Product keeps only the low 15 magnitude bits; a start while busy is dropped, result valid at finish
`timescale 1ns/1ps
`include "calc_params.svh"

module sm_multiplier (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   start,
    input  logic [`CALC_WIDTH-1:0] a,
    input  logic [`CALC_WIDTH-1:0] b,
    output logic [`CALC_WIDTH-1:0] result,
    output logic                   finish
);

    logic                                busy;
    logic [$clog2(`CALC_MULT_STEPS)-1:0] step;
    logic                                last_step;
    logic [`CALC_MAG_WIDTH-1:0]          acc;
    logic [`CALC_MAG_WIDTH-1:0]          acc_next;
    logic [`CALC_MAG_WIDTH-1:0]          mcand;
    logic [`CALC_MAG_WIDTH-1:0]          mplier;
    logic                                sign_r;

    // Add the shifted multiplicand when the current multiplier bit is set
    assign acc_next  = mplier[0] ? acc + mcand : acc;
    assign last_step = (step == `CALC_MULT_STEPS - 1);

    // Step counter and handshake
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end else if (start) begin
                busy <= 1'b1;
                step <= '0;
            end
        end
    end

    // Shift-and-add datapath that drops bits above the magnitude
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            acc    <= '0;
            mcand  <= a[`CALC_MAG_WIDTH-1:0];
            mplier <= b[`CALC_MAG_WIDTH-1:0];
            sign_r <= a[`CALC_WIDTH-1] ^ b[`CALC_WIDTH-1];
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Zero product is always positive
    assign result = {sign_r & (|acc), acc};

endmodule

/* logic/operand_regs.sv */
// Only one control strobe per cycle is expected; clear wins, and the entry product keeps the sign
`timescale 1ns/1ps
`include "calc_params.svh"

module operand_regs (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic [`CALC_DIGIT_WIDTH-1:0] digit,
    input  logic                         sel_b,
    input  logic                         latch_digit,
    input  logic                         toggle_sign,
    input  logic                         load_product,
    input  logic                         add_digit,
    input  logic                         clear_operands,
    input  calc_pkg::mult_src_t          mult_src,
    input  logic [`CALC_WIDTH-1:0]       mult_result,
    output logic [`CALC_WIDTH-1:0]       operand_a,
    output logic [`CALC_WIDTH-1:0]       operand_b,
    output logic [`CALC_WIDTH-1:0]       mult_a,
    output logic [`CALC_WIDTH-1:0]       mult_b
);

    logic [`CALC_DIGIT_WIDTH-1:0] digit_r;
    logic [`CALC_WIDTH-1:0]       target;
    logic [`CALC_WIDTH-1:0]       target_next;
    logic                         target_we;

    assign target    = sel_b ? operand_b : operand_a;
    assign target_we = toggle_sign | load_product | add_digit;

    always_comb begin
        target_next = target;
        if (toggle_sign) begin
            target_next[`CALC_WIDTH-1] = ~target[`CALC_WIDTH-1];
        end else if (load_product) begin
            // Only the magnitude comes from the product
            target_next[`CALC_MAG_WIDTH-1:0] = mult_result[`CALC_MAG_WIDTH-1:0];
        end else if (add_digit) begin
            target_next[`CALC_MAG_WIDTH-1:0] = target[`CALC_MAG_WIDTH-1:0]
                + {{(`CALC_MAG_WIDTH-`CALC_DIGIT_WIDTH){1'b0}}, digit_r};
        end
    end

    always_ff @(posedge clk) begin
        if (latch_digit) begin
            digit_r <= digit;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand_a <= '0;
            operand_b <= '0;
        end else if (clear_operands) begin
            operand_a <= '0;
            operand_b <= '0;
        end else if (target_we) begin
            if (sel_b) begin
                operand_b <= target_next;
            end else begin
                operand_a <= target_next;
            end
        end
    end

    // Entry shifts the target by ten, compute multiplies A by B
    always_comb begin
        if (mult_src == calc_pkg::MSRC_COMPUTE) begin
            mult_a = operand_a;
            mult_b = operand_b;
        end else begin
            mult_a = target;
            mult_b = `CALC_ENTRY_SCALE;
        end
    end

endmodule

/* logic/calc_fsm.sv */
// Keys outside WAIT states are dropped, operators after the first are ignored, no result chaining
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_fsm (
    input  logic                   clk,
    input  logic                   nRST,
    input  calc_pkg::key_event_t   key,
    input  logic                   add_finish,
    input  logic                   mult_finish,
    input  logic [`CALC_WIDTH-1:0] add_result,
    input  logic [`CALC_WIDTH-1:0] mult_result,
    output logic                   key_read,
    output logic                   sel_b,
    output logic                   latch_digit,
    output logic                   toggle_sign,
    output logic                   load_product,
    output logic                   add_digit,
    output logic                   clear_operands,
    output calc_pkg::mult_src_t    mult_src,
    output logic                   start_add,
    output logic                   sub,
    output logic                   start_mult,
    output logic                   complete,
    output logic [`CALC_WIDTH-1:0] display
);

    calc_pkg::state_t  state;
    calc_pkg::state_t  next_state;
    calc_pkg::opcode_t op_r;
    logic              in_wait;
    logic              take_digit;
    logic              take_neg;
    logic              take_arith;
    logic              show;

    assign in_wait    = (state == calc_pkg::WAIT_OP1) || (state == calc_pkg::WAIT_OP2);
    assign take_digit = in_wait && key.digit_valid;
    assign take_neg   = in_wait && (key.op == calc_pkg::OP_NEG);
    assign take_arith = (state == calc_pkg::WAIT_OP1)
        && (key.op inside {calc_pkg::OP_ADD, calc_pkg::OP_SUB, calc_pkg::OP_MUL});
    assign show       = (state == calc_pkg::SHOW_ADDSUB) || (state == calc_pkg::SHOW_MULT);

    // Operand register controls
    assign sel_b = state inside {calc_pkg::WAIT_OP2, calc_pkg::SHIFT_OP2,
                                 calc_pkg::ADD_DIGIT_OP2};
    assign latch_digit    = take_digit;
    assign toggle_sign    = take_neg;
    assign load_product   = mult_finish
        && ((state == calc_pkg::SHIFT_OP1) || (state == calc_pkg::SHIFT_OP2));
    assign add_digit      = (state == calc_pkg::ADD_DIGIT_OP1)
        || (state == calc_pkg::ADD_DIGIT_OP2);
    assign clear_operands = show;
    assign mult_src = (state inside {calc_pkg::SEND_COMPUTE, calc_pkg::WAIT_COMPUTE,
                                     calc_pkg::SHOW_MULT})
        ? calc_pkg::MSRC_COMPUTE : calc_pkg::MSRC_ENTRY;
    assign sub = (op_r == calc_pkg::OP_SUB);

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::WAIT_OP1: begin
                if (key.digit_valid) begin
                    next_state = calc_pkg::SHIFT_OP1;
                end else if (take_arith) begin
                    next_state = calc_pkg::WAIT_OP2;
                end else if (key.equal) begin
                    next_state = calc_pkg::SEND_COMPUTE;
                end
            end
            calc_pkg::WAIT_OP2: begin
                if (key.digit_valid) begin
                    next_state = calc_pkg::SHIFT_OP2;
                end else if (key.equal) begin
                    next_state = calc_pkg::SEND_COMPUTE;
                end
            end
            calc_pkg::SHIFT_OP1: begin
                if (mult_finish) begin
                    next_state = calc_pkg::ADD_DIGIT_OP1;
                end
            end
            calc_pkg::SHIFT_OP2: begin
                if (mult_finish) begin
                    next_state = calc_pkg::ADD_DIGIT_OP2;
                end
            end
            calc_pkg::ADD_DIGIT_OP1: next_state = calc_pkg::WAIT_OP1;
            calc_pkg::ADD_DIGIT_OP2: next_state = calc_pkg::WAIT_OP2;
            calc_pkg::SEND_COMPUTE: begin
                // Equal without an operator gives no result
                if (op_r == calc_pkg::OP_NONE) begin
                    next_state = calc_pkg::WAIT_OP1;
                end else begin
                    next_state = calc_pkg::WAIT_COMPUTE;
                end
            end
            calc_pkg::WAIT_COMPUTE: begin
                if (add_finish) begin
                    next_state = calc_pkg::SHOW_ADDSUB;
                end else if (mult_finish) begin
                    next_state = calc_pkg::SHOW_MULT;
                end
            end
            default: next_state = calc_pkg::WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= calc_pkg::WAIT_OP1;
            op_r       <= calc_pkg::OP_NONE;
            key_read   <= 1'b0;
            start_add  <= 1'b0;
            start_mult <= 1'b0;
            complete   <= 1'b0;
            display    <= '0;
        end else begin
            state      <= next_state;
            key_read   <= take_digit || take_neg;
            start_add  <= (state == calc_pkg::SEND_COMPUTE)
                && ((op_r == calc_pkg::OP_ADD) || (op_r == calc_pkg::OP_SUB));
            // Entry shift and the compute multiply share the one multiplier
            start_mult <= take_digit
                || ((state == calc_pkg::SEND_COMPUTE) && (op_r == calc_pkg::OP_MUL));
            complete   <= show;
            if (take_arith) begin
                op_r <= key.op;
            end else if (show) begin
                op_r <= calc_pkg::OP_NONE;
            end
            if (state == calc_pkg::SHOW_ADDSUB) begin
                display <= add_result;
            end else if (state == calc_pkg::SHOW_MULT) begin
                display <= mult_result;
            end
        end
    end

endmodule

/* logic/calc_top.sv */
// Expects one-cycle key strobes from an external debounced controller; no back-pressure
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_top (
    input  logic                   clk,
    input  logic                   nRST,
    input  calc_pkg::key_event_t   key,
    output logic                   key_read,
    output logic                   complete,
    output logic [`CALC_WIDTH-1:0] display
);

    logic                   sel_b;
    logic                   latch_digit;
    logic                   toggle_sign;
    logic                   load_product;
    logic                   add_digit;
    logic                   clear_operands;
    calc_pkg::mult_src_t    mult_src;
    logic                   start_add;
    logic                   sub;
    logic                   start_mult;
    logic                   add_finish;
    logic                   mult_finish;
    logic [`CALC_WIDTH-1:0] add_result;
    logic [`CALC_WIDTH-1:0] mult_result;
    logic [`CALC_WIDTH-1:0] operand_a;
    logic [`CALC_WIDTH-1:0] operand_b;
    logic [`CALC_WIDTH-1:0] mult_a;
    logic [`CALC_WIDTH-1:0] mult_b;

    calc_fsm fsm_i (
        .clk            (clk),
        .nRST           (nRST),
        .key            (key),
        .add_finish     (add_finish),
        .mult_finish    (mult_finish),
        .add_result     (add_result),
        .mult_result    (mult_result),
        .key_read       (key_read),
        .sel_b          (sel_b),
        .latch_digit    (latch_digit),
        .toggle_sign    (toggle_sign),
        .load_product   (load_product),
        .add_digit      (add_digit),
        .clear_operands (clear_operands),
        .mult_src       (mult_src),
        .start_add      (start_add),
        .sub            (sub),
        .start_mult     (start_mult),
        .complete       (complete),
        .display        (display)
    );

    operand_regs operands_i (
        .clk            (clk),
        .nRST           (nRST),
        .digit          (key.digit),
        .sel_b          (sel_b),
        .latch_digit    (latch_digit),
        .toggle_sign    (toggle_sign),
        .load_product   (load_product),
        .add_digit      (add_digit),
        .clear_operands (clear_operands),
        .mult_src       (mult_src),
        .mult_result    (mult_result),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .mult_a         (mult_a),
        .mult_b         (mult_b)
    );

    sm_adder adder_i (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_add),
        .sub    (sub),
        .a      (operand_a),
        .b      (operand_b),
        .result (add_result),
        .finish (add_finish)
    );

    sm_multiplier mult_i (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_mult),
        .a      (mult_a),
        .b      (mult_b),
        .result (mult_result),
        .finish (mult_finish)
    );

endmodule

/* testbench/calc_asserts.sv */
// Relies on calc_top internal signal names; all but the reset check are disabled while nRST is low
`timescale 1ns/1ps

module calc_asserts (
    input logic clk,
    input logic nRST,
    input logic key_read,
    input logic complete,
    input logic start_add,
    input logic start_mult,
    input logic add_finish
);

    int fail_count = 0;

    complete_one_cycle: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else begin
            fail_count++;
            $error("complete stayed high for more than one cycle");
        end

    // Entry shift and compute never share a start cycle
    starts_exclusive: assert property (@(posedge clk) disable iff (!nRST)
        !(start_add && start_mult))
        else begin
            fail_count++;
            $error("start_add and start_mult high together");
        end

    add_finish_latency: assert property (@(posedge clk) disable iff (!nRST)
        add_finish == $past(start_add))
        else begin
            fail_count++;
            $error("add_finish did not follow start_add by one cycle");
        end

    reset_outputs_low: assert property (@(posedge clk)
        $rose(nRST) |-> (!key_read && !complete))
        else begin
            fail_count++;
            $error("key_read or complete high right after reset");
        end

endmodule

/* testbench/calc_tb.sv */
// Sends one key per FSM wait state and reads the FSM state hierarchically; seeded random stimulus
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_tb;

    localparam int SETTLE_TIMEOUT  = 25;
    localparam int COMPUTE_TIMEOUT = 60;
    localparam int NOOP_TIMEOUT    = 30;
    localparam int ADDSUB_LATENCY  = 5;
    localparam int MAG_MOD         = 1 << `CALC_MAG_WIDTH;

    logic                   clk;
    logic                   nRST;
    calc_pkg::key_event_t   key;
    logic                   key_read;
    logic                   complete;
    logic [`CALC_WIDTH-1:0] display;

    logic [`CALC_WIDTH-1:0] expected;
    int                     error_count = 0;
    int                     display_errors = 0;
    int                     complete_count = 0;
    int                     key_read_count = 0;
    int                     test_count = 0;
    int                     test_fail_count = 0;
    int                     errors_at_start = 0;
    string                  test_name;
    integer                 seed = 32'h16ea_3b8b;

    calc_top dut_i (
        .clk      (clk),
        .nRST     (nRST),
        .key      (key),
        .key_read (key_read),
        .complete (complete),
        .display  (display)
    );

    bind calc_top calc_asserts asserts_i (
        .clk        (clk),
        .nRST       (nRST),
        .key_read   (key_read),
        .complete   (complete),
        .start_add  (start_add),
        .start_mult (start_mult),
        .add_finish (add_finish)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Result check at every complete pulse
    always @(negedge clk) begin
        if (nRST && complete) begin
            complete_count++;
            if (display !== expected) begin
                $display("[ERROR] %0t display: expected %h, got %h", $time, expected, display);
                display_errors++;
            end
        end
    end

    always @(negedge clk) begin
        if (nRST && key_read) begin
            key_read_count++;
        end
    end

    // Weight of the leading digit is 10^(n-1)
    function automatic int decimal_scale(input int n_digits);
        int scale;
        int i;
        scale = 1;
        for (i = 1; i < n_digits; i++) begin
            scale = scale * 10;
        end
        return scale;
    endfunction

    function automatic logic [`CALC_WIDTH-1:0] entry_operand(input int value, input int n_digits,
                                                             input int toggles);
        int mag;
        int scale;
        int i;
        mag = 0;
        scale = decimal_scale(n_digits);
        for (i = 0; i < n_digits; i++) begin
            mag = (mag * `CALC_ENTRY_SCALE + (value / scale) % 10) % MAG_MOD;
            scale = scale / 10;
        end
        return {toggles[0], mag[`CALC_MAG_WIDTH-1:0]};
    endfunction

    function automatic logic [`CALC_WIDTH-1:0] calc_ref(
        input int a_val, input int a_n, input int a_toggles, input calc_pkg::opcode_t op,
        input int b_val, input int b_n, input int b_toggles);
        logic [`CALC_WIDTH-1:0] a;
        logic [`CALC_WIDTH-1:0] b;
        logic                   sign_a;
        logic                   sign_b;
        logic                   sign_r;
        int                     mag_a;
        int                     mag_b;
        int                     mag_r;
        a = entry_operand(a_val, a_n, a_toggles);
        b = entry_operand(b_val, b_n, b_toggles);
        sign_a = a[`CALC_WIDTH-1];
        sign_b = b[`CALC_WIDTH-1];
        mag_a = int'(a[`CALC_MAG_WIDTH-1:0]);
        mag_b = int'(b[`CALC_MAG_WIDTH-1:0]);
        if (op == calc_pkg::OP_MUL) begin
            mag_r = (mag_a * mag_b) % MAG_MOD;
            sign_r = sign_a ^ sign_b;
        end else begin
            if (op == calc_pkg::OP_SUB) begin
                sign_b = ~sign_b;
            end
            if (sign_a == sign_b) begin
                mag_r = (mag_a + mag_b) % MAG_MOD;
                sign_r = sign_a;
            end else if (mag_a > mag_b) begin
                mag_r = mag_a - mag_b;
                sign_r = sign_a;
            end else begin
                mag_r = mag_b - mag_a;
                sign_r = sign_b;
            end
        end
        if (mag_r == 0) begin
            sign_r = 1'b0;
        end
        return {sign_r, mag_r[`CALC_MAG_WIDTH-1:0]};
    endfunction

    function automatic bit fsm_waiting();
        return (dut_i.fsm_i.state == calc_pkg::WAIT_OP1)
            || (dut_i.fsm_i.state == calc_pkg::WAIT_OP2);
    endfunction

    task automatic check_int(input string name, input int exp_v, input int got_v);
        if (exp_v != got_v) begin
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp_v, got_v);
            error_count++;
        end
    endtask

    // One key strobe, then wait for the FSM to settle back in a wait state
    task automatic send_key(input calc_pkg::key_event_t k, input int reads_expected);
        int reads_before;
        int cycles;
        reads_before = key_read_count;
        key = k;
        @(posedge clk);
        #2;
        key = '0;
        @(posedge clk);
        #2;
        cycles = 1;
        while (!fsm_waiting() && cycles < SETTLE_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!fsm_waiting()) begin
            $display("%s: FSM did not return to a wait state within %0d cycles after a key",
                     test_name, SETTLE_TIMEOUT);
            error_count++;
        end else begin
            check_int("key_read pulses", reads_expected, key_read_count - reads_before);
        end
    endtask

    task automatic press_digit(input logic [`CALC_DIGIT_WIDTH-1:0] d);
        calc_pkg::key_event_t k;
        k = '0;
        k.digit = d;
        k.digit_valid = 1'b1;
        send_key(k, 1);
    endtask

    task automatic press_op(input calc_pkg::opcode_t op);
        calc_pkg::key_event_t k;
        k = '0;
        k.op = op;
        send_key(k, (op == calc_pkg::OP_NEG) ? 1 : 0);
    endtask

    task automatic press_equal();
        key = '0;
        key.equal = 1'b1;
        @(posedge clk);
        #2;
        key = '0;
    endtask

    // First toggle goes after the leading digit, the rest after the last digit
    task automatic enter_operand(input int value, input int n_digits, input int toggles);
        int scale;
        int i;
        int t;
        int digit_val;
        scale = decimal_scale(n_digits);
        t = toggles;
        for (i = 0; i < n_digits; i++) begin
            digit_val = (value / scale) % 10;
            press_digit(digit_val[`CALC_DIGIT_WIDTH-1:0]);
            scale = scale / 10;
            if (i == 0 && t > 0) begin
                press_op(calc_pkg::OP_NEG);
                t--;
            end
        end
        while (t > 0) begin
            press_op(calc_pkg::OP_NEG);
            t--;
        end
    endtask

    task automatic wait_complete(input int limit, output bit seen, output int cycles);
        cycles = 1;
        while (!complete && cycles < limit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        seen = complete;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count + display_errors;
    endtask

    task automatic finish_test();
        int new_errors;
        new_errors = error_count + display_errors - errors_at_start;
        test_count++;
        if (new_errors == 0) begin
            $display("test %0d %s: ok", test_count, test_name);
        end else begin
            test_fail_count++;
            $display("test %0d %s: %0d error(s)", test_count, test_name, new_errors);
        end
    endtask

    task automatic run_calc(input int a_val, input int a_n, input int a_toggles,
                            input calc_pkg::opcode_t op,
                            input int b_val, input int b_n, input int b_toggles,
                            input bit check_latency);
        int completes_before;
        int cycles;
        bit seen;
        expected = calc_ref(a_val, a_n, a_toggles, op, b_val, b_n, b_toggles);
        enter_operand(a_val, a_n, a_toggles);
        press_op(op);
        enter_operand(b_val, b_n, b_toggles);
        completes_before = complete_count;
        press_equal();
        wait_complete(COMPUTE_TIMEOUT, seen, cycles);
        if (!seen) begin
            $display("%s: no complete within %0d cycles after equal", test_name, COMPUTE_TIMEOUT);
            error_count++;
        end else begin
            if (check_latency) begin
                check_int("complete latency", ADDSUB_LATENCY, cycles);
            end
            repeat (2) begin
                @(posedge clk);
            end
            #2;
            check_int("complete pulses", 1, complete_count - completes_before);
        end
    endtask

    initial begin
        int i;
        int a_val;
        int b_val;
        int a_n;
        int b_n;
        int a_t;
        int b_t;
        int r;
        int reads_before;
        int cycles;
        int total_errors;
        bit seen;
        calc_pkg::opcode_t op;

        nRST = 1'b0;
        key = '0;
        expected = '0;
        repeat (2) begin
            @(posedge clk);
        end
        #2;
        nRST = 1'b1;

        start_test("reset_idle");
        check_int("display", 0, int'(display));
        repeat (8) begin
            @(posedge clk);
            #2;
            check_int("complete", 0, int'(complete));
            check_int("key_read", 0, int'(key_read));
        end
        finish_test();

        start_test("add_123_45");
        run_calc(123, 3, 0, calc_pkg::OP_ADD, 45, 2, 0, 1'b1);
        finish_test();
        start_test("sub_45_123");
        run_calc(45, 2, 0, calc_pkg::OP_SUB, 123, 3, 0, 1'b1);
        finish_test();

        start_test("mul_12_34");
        run_calc(12, 2, 0, calc_pkg::OP_MUL, 34, 2, 0, 1'b0);
        finish_test();
        start_test("mul_300_300_wrap");
        run_calc(300, 3, 0, calc_pkg::OP_MUL, 300, 3, 0, 1'b0);
        finish_test();
        start_test("mul_neg_12_34");
        run_calc(12, 2, 1, calc_pkg::OP_MUL, 34, 2, 0, 1'b0);
        finish_test();

        start_test("sub_neg7_neg7");
        run_calc(7, 1, 1, calc_pkg::OP_SUB, 7, 1, 1, 1'b1);
        finish_test();
        start_test("add_5_neg9");
        run_calc(5, 1, 0, calc_pkg::OP_ADD, 9, 1, 1, 1'b1);
        finish_test();
        start_test("double_toggle");
        run_calc(81, 2, 2, calc_pkg::OP_SUB, 6, 1, 1, 1'b1);
        finish_test();

        for (i = 0; i < 20; i++) begin
            a_n = 1 + $unsigned($random(seed)) % 4;
            b_n = 1 + $unsigned($random(seed)) % 4;
            a_val = $unsigned($random(seed)) % decimal_scale(a_n + 1);
            b_val = $unsigned($random(seed)) % decimal_scale(b_n + 1);
            a_t = $unsigned($random(seed)) % 3;
            b_t = $unsigned($random(seed)) % 3;
            r = $unsigned($random(seed)) % 3;
            if (r == 0) begin
                op = calc_pkg::OP_ADD;
            end else if (r == 1) begin
                op = calc_pkg::OP_SUB;
            end else begin
                op = calc_pkg::OP_MUL;
            end
            start_test($sformatf("random_%0d", i));
            run_calc(a_val, a_n, a_t, op, b_val, b_n, b_t, (op != calc_pkg::OP_MUL));
            finish_test();
        end

        // Leaves operand A loaded, so it runs last
        start_test("equal_without_op");
        reads_before = key_read_count;
        r = complete_count;
        enter_operand(42, 2, 1);
        press_equal();
        wait_complete(NOOP_TIMEOUT, seen, cycles);
        if (seen) begin
            $display("%s: complete pulsed for an equal with no operator", test_name);
            error_count++;
        end
        check_int("complete pulses", 0, complete_count - r);
        check_int("key_read pulses", 3, key_read_count - reads_before);
        if (dut_i.fsm_i.state != calc_pkg::WAIT_OP1) begin
            $display("%s: FSM did not return to WAIT_OP1", test_name);
            error_count++;
        end
        finish_test();

        total_errors = error_count + display_errors + dut_i.asserts_i.fail_count;
        $display("tests: %0d run, %0d failed; checks failed: %0d; assertions failed: %0d",
                 test_count, test_fail_count, error_count + display_errors,
                 dut_i.asserts_i.fail_count);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+include
logic/calc_pkg.sv
logic/sm_adder.sv
logic/sm_multiplier.sv
logic/operand_regs.sv
logic/calc_fsm.sv
logic/calc_top.sv
testbench/calc_asserts.sv
testbench/calc_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the calculator testbench with Verilator; the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module calc_tb -f project.f -Mdir obj_dir -o calc_sim

./obj_dir/calc_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
